/* include/commitCheck.svh */
`ifndef COMMIT_CHECK_SVH
`define COMMIT_CHECK_SVH

task automatic failCheck(input string name, input string expStr, input string actStr);
    $display("MISMATCH %s expected %s actual %s", name, expStr, actStr);
    $display("tests failed");
    $fatal(1, "check %s failed", name);
endtask

// Payload fields only matter on a valid slot.
task automatic checkCommit(input string name, input commitPkg::commitSlot_t expSlot,
                           input commitPkg::commitSlot_t actSlot);
    logic bad;
    bad = expSlot.valid !== actSlot.valid || expSlot.wrReg !== actSlot.wrReg;
    if (expSlot.valid && !bad) begin
        bad = expSlot.arf !== actSlot.arf || expSlot.prf !== actSlot.prf
              || expSlot.stale !== actSlot.stale;
    end
    if (bad) failCheck(name, $sformatf("%p", expSlot), $sformatf("%p", actSlot));
endtask

task automatic checkExc(input string name, input commitPkg::excReport_t expExc,
                        input commitPkg::excReport_t actExc);
    logic bad;
    bad = expExc.take !== actExc.take;
    if (expExc.take && !bad) begin
        bad = expExc.code !== actExc.code || expExc.badVAddr !== actExc.badVAddr
              || expExc.pc !== actExc.pc || expExc.isDS !== actExc.isDS
              || expExc.intLines !== actExc.intLines;
    end
    if (bad) failCheck(name, $sformatf("%p", expExc), $sformatf("%p", actExc));
endtask

task automatic checkRedirect(input string name, input commitPkg::redirect_t expRed,
                             input commitPkg::redirect_t actRed);
    if (expRed.valid !== actRed.valid || (expRed.valid && expRed.pc !== actRed.pc)) begin
        failCheck(name, $sformatf("%p", expRed), $sformatf("%p", actRed));
    end
endtask

task automatic checkFree(input string name, input logic [commitPkg::PRF_W-1:0] expTag,
                         input logic [commitPkg::PRF_W-1:0] actTag);
    if (expTag !== actTag) begin
        failCheck(name, $sformatf("%0d", expTag), $sformatf("%0d", actTag));
    end
endtask

`endif

/* bench/commitTb.sv */
`timescale 1ns/1ps

module commitTb;

    logic                        clk = 1'b0;
    logic                        rst;
    logic [4:0]                  extInt;
    commitPkg::cp0Status_t       cp0;
    commitPkg::robWindow_t       robWin;
    commitPkg::commitSlot_t      commit0;
    commitPkg::commitSlot_t      commit1;
    logic [1:0]                  freeValid;
    logic [commitPkg::PRF_W-1:0] freeTag0;
    logic [commitPkg::PRF_W-1:0] freeTag1;
    logic [1:0]                  storeFire;
    commitPkg::excReport_t       excOut;
    commitPkg::redirect_t        redir;
    logic                        flush;

    logic [commitPkg::PRF_W-1:0] mdlMap [commitPkg::NUM_ARF]; // Committed map model.
    logic                        mdlWait;
    logic [31:0]                 mdlTarget;
    logic                        intOn;
    commitPkg::commitSlot_t      expC0;
    commitPkg::commitSlot_t      expC1;
    commitPkg::excReport_t       expExc;
    commitPkg::redirect_t        expRed;
    logic [1:0]                  expStore;

    `include "commitCheck.svh"

    commitTop u_dut (
        .clk(clk), .rst(rst), .extInt(extInt), .cp0(cp0), .robWin(robWin),
        .commit0(commit0), .commit1(commit1), .freeValid(freeValid),
        .freeTag0(freeTag0), .freeTag1(freeTag1), .storeFire(storeFire),
        .excOut(excOut), .redir(redir), .flush(flush)
    );

    always #20 clk = ~clk;

    // Branches here are always predicted right.
    function automatic commitPkg::robUop_t randUop();
        commitPkg::robUop_t u;
        u = '0;
        u.valid = ($urandom % 8) != 0;
        u.busy  = ($urandom % 8) == 0;
        case ($urandom % 3)
            0:       u.kind = commitPkg::kindNormal;
            1:       u.kind = commitPkg::kindStore;
            default: u.kind = commitPkg::kindBranch;
        endcase
        u.pc                  = $urandom & 32'hFFFF_FFFC;
        u.branchAddr          = $urandom & 32'hFFFF_FFFC;
        u.isDS                = 1'($urandom);
        u.aux.br.branchTaken  = 1'($urandom);
        u.aux.br.predTaken    = u.aux.br.branchTaken;
        u.aux.br.predAddr     = u.branchAddr;
        u.dstWe               = 1'($urandom);
        u.dstL                = 5'($urandom);
        u.dstP                = 6'($urandom);
        return u;
    endfunction

    function automatic commitPkg::robUop_t goodUop();
        commitPkg::robUop_t u;
        u = randUop();
        u.valid = 1'b1;
        u.busy  = 1'b0;
        return u;
    endfunction

    function automatic commitPkg::robUop_t excUop(input commitPkg::excCode_e code);
        commitPkg::robUop_t u;
        u = goodUop();
        u.kind = (code == commitPkg::excEret) ? commitPkg::kindEret : commitPkg::kindNormal;
        u.causeExc           = 1'b1;
        u.aux                = '0;
        u.aux.exc.code       = code;
        u.aux.exc.badVAddr   = $urandom;
        return u;
    endfunction

    function automatic commitPkg::robUop_t wrongBranch();
        commitPkg::robUop_t u;
        u = goodUop();
        u.kind = commitPkg::kindBranch;
        if ($urandom % 2 == 0) begin
            u.aux.br.predTaken = !u.aux.br.branchTaken; // Wrong direction.
        end else begin
            u.aux.br.branchTaken = 1'b1;
            u.aux.br.predTaken   = 1'b1;
            u.aux.br.predAddr    = u.branchAddr ^ 32'h0000_0010;
        end
        return u;
    endfunction

    // Fills stale tags from the model map and derives every expected result.
    task automatic modelWindow(inout commitPkg::robWindow_t win);
        logic g0;
        logic g1;
        logic e0;
        logic e1;
        logic it;
        logic s0;
        logic mis;
        g0 = win.valid && win.uop0.valid && !win.uop0.busy;
        g1 = win.valid && win.uop1.valid && !win.uop1.busy;
        e0 = g0 && win.uop0.causeExc;
        e1 = g1 && win.uop1.causeExc;
        it = g0 && intOn;
        s0 = it || e0;
        win.uop0.dstStale = mdlMap[win.uop0.dstL];
        expC0.valid = g0;
        expC0.wrReg = g0 && win.uop0.dstWe && !s0;
        expC0.arf   = win.uop0.dstL;
        expC0.prf   = win.uop0.dstP;
        expC0.stale = win.uop0.dstStale;
        if (expC0.wrReg) begin
            mdlMap[win.uop0.dstL] = win.uop0.dstP;
        end
        win.uop1.dstStale = mdlMap[win.uop1.dstL]; // Sees slot 0's write.
        expC1.valid = g1;
        expC1.wrReg = g1 && win.uop1.dstWe && !s0 && !e1;
        expC1.arf   = win.uop1.dstL;
        expC1.prf   = win.uop1.dstP;
        expC1.stale = win.uop1.dstStale;
        if (expC1.wrReg) begin
            mdlMap[win.uop1.dstL] = win.uop1.dstP;
        end
        expStore[0] = g0 && win.uop0.kind == commitPkg::kindStore;
        expStore[1] = g1 && win.uop1.kind == commitPkg::kindStore;
        expExc      = '0;
        expExc.take = it || e0 || e1;
        if (it) begin
            expExc.code = commitPkg::excInterrupt;
        end else if (e0) begin
            expExc.code = win.uop0.aux.exc.code;
        end else begin
            expExc.code = win.uop1.aux.exc.code;
        end
        expExc.badVAddr = s0 ? win.uop0.aux.exc.badVAddr : win.uop1.aux.exc.badVAddr;
        expExc.pc       = s0 ? win.uop0.pc : win.uop1.pc;
        expExc.isDS     = s0 ? win.uop0.isDS : win.uop1.isDS;
        expExc.intLines = {cp0.counterInt, extInt}; // Lines held steady before the strobe.
        mis = g0 && !win.uop0.causeExc && win.uop0.kind == commitPkg::kindBranch
              && (win.uop0.aux.br.predTaken != win.uop0.aux.br.branchTaken
                  || (win.uop0.aux.br.branchTaken
                      && win.uop0.aux.br.predAddr != win.uop0.branchAddr));
        expRed = '0;
        if (expExc.take) begin
            expRed.valid = 1'b1;
            expRed.pc    = (expExc.code == commitPkg::excEret) ? cp0.epc : commitPkg::EXC_VECTOR;
        end else if (mis) begin
            mdlTarget    = win.uop0.aux.br.branchTaken ? win.uop0.branchAddr : win.uop0.pc + 32'd8;
            mdlWait      = win.uop1.kind == commitPkg::kindBubble;
            expRed.valid = !mdlWait;
            expRed.pc    = mdlTarget;
        end else if (mdlWait && (g0 || g1)) begin
            mdlWait      = 1'b0; // Delay slot arrived.
            expRed.valid = 1'b1;
            expRed.pc    = mdlTarget;
        end
    endtask

    task automatic runWindow(input string name, input commitPkg::robWindow_t win);
        int lat;
        modelWindow(win);
        @(posedge clk);
        robWin <= win;
        @(negedge clk);
        if (storeFire !== expStore) begin
            failCheck({name, " storeFire"}, $sformatf("%b", expStore), $sformatf("%b", storeFire));
        end
        @(posedge clk);
        robWin.valid <= 1'b0;
        @(negedge clk);
        lat = 1;
        while (expRed.valid && !flush) begin
            if (lat >= 8) begin
                $display("%s: no flush within %0d cycles after the window", name, lat);
                $display("tests failed");
                $fatal(1, "flush timeout");
            end
            @(posedge clk);
            @(negedge clk);
            lat++;
        end
        if (lat != 1) begin
            failCheck({name, " flush latency"}, "1", $sformatf("%0d", lat));
        end
        if (flush !== expRed.valid) begin
            failCheck({name, " flush"}, $sformatf("%b", expRed.valid), $sformatf("%b", flush));
        end
        checkCommit({name, " commit0"}, expC0, commit0);
        checkCommit({name, " commit1"}, expC1, commit1);
        checkExc({name, " exc"}, expExc, excOut);
        checkRedirect({name, " redir"}, expRed, redir);
        if (freeValid !== {expC1.wrReg, expC0.wrReg}) begin
            failCheck({name, " freeValid"}, $sformatf("%b", {expC1.wrReg, expC0.wrReg}),
                      $sformatf("%b", freeValid));
        end
        if (expC0.wrReg) checkFree({name, " freeTag0"}, expC0.stale, freeTag0);
        if (expC1.wrReg) checkFree({name, " freeTag1"}, expC1.stale, freeTag1);
        if (expRed.valid) begin
            @(posedge clk); // Idle cycle behind a flush.
        end
    endtask

    initial begin
        commitPkg::robWindow_t win;
        commitPkg::cp0Status_t cpInit;
        void'($urandom(32'h0262_1b9a));
        cpInit     = '0;
        cpInit.epc = $urandom & 32'hFFFF_FFFC;
        rst    <= 1'b1;
        extInt <= '0;
        cp0    <= cpInit;
        robWin <= '0;
        for (int i = 0; i < commitPkg::NUM_ARF; i++) begin
            mdlMap[i] = commitPkg::PRF_W'(i);
        end
        mdlWait   = 1'b0;
        mdlTarget = '0;
        intOn     = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkCommit("reset commit0", '0, commit0);
        checkCommit("reset commit1", '0, commit1);
        checkExc("reset exc", '0, excOut);
        checkRedirect("reset redir", '0, redir);
        if ({storeFire, freeValid, flush} !== 5'b0) begin
            failCheck("reset strobes", "0", $sformatf("%b", {storeFire, freeValid, flush}));
        end

        win.valid = 1'b1;
        for (int n = 0; n < 200; n++) begin
            win.uop0 = randUop();
            win.uop1 = randUop();
            runWindow($sformatf("random %0d", n), win);
        end

        for (int n = 0; n < 24; n++) begin
            win.uop0 = goodUop();
            win.uop1 = goodUop();
            if (n % 2 == 0) begin
                win.uop0 = excUop(commitPkg::excCode_e'(5'(1 + $urandom % 7)));
            end else begin
                win.uop1 = excUop(commitPkg::excCode_e'(5'(1 + $urandom % 7)));
            end
            runWindow($sformatf("exception %0d", n), win);
        end

        @(posedge clk);
        cp0.ie <= 1'b1;
        cp0.im <= 6'b000001;
        extInt <= 5'b00001;
        @(posedge clk); // Lines are registered once.
        intOn    = 1'b1;
        win.uop0 = goodUop();
        win.uop1 = goodUop();
        runWindow("interrupt", win);
        @(posedge clk);
        cp0.exl <= 1'b1;
        intOn = 1'b0;
        win.uop0 = goodUop();
        win.uop1 = goodUop();
        runWindow("interrupt under exl", win);
        @(posedge clk);
        extInt  <= '0;
        cp0.ie  <= 1'b0;
        cp0.exl <= 1'b0;

        for (int n = 0; n < 12; n++) begin
            win.uop0 = wrongBranch();
            win.uop1 = goodUop();
            win.uop1.kind = commitPkg::kindNormal;
            runWindow($sformatf("mispredict filled %0d", n), win);
        end

        for (int n = 0; n < 12; n++) begin
            win.uop0 = wrongBranch();
            win.uop1 = goodUop();
            win.uop1.kind  = commitPkg::kindBubble;
            win.uop1.dstWe = 1'b0;
            runWindow($sformatf("mispredict bubble %0d", n), win);
            repeat (3) begin
                @(negedge clk);
                checkRedirect("bubble wait", '0, redir);
            end
            win.uop0 = goodUop();
            win.uop0.kind = commitPkg::kindNormal;
            win.uop1 = goodUop();
            runWindow($sformatf("delay slot %0d", n), win);
        end

        for (int n = 0; n < 16; n++) begin
            win.uop0 = goodUop();
            win.uop1 = goodUop();
            win.uop0.dstWe = 1'b1;
            win.uop1.dstWe = 1'b1;
            win.uop1.dstL  = win.uop0.dstL; // Same register in both slots.
            runWindow($sformatf("same register %0d", n), win);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

/* hw/archMap.sv */
`timescale 1ns/1ps

module archMap (
    input  logic                                clk,
    input  logic                                rst,
    input  commitPkg::commitSlot_t              commit0,
    input  commitPkg::commitSlot_t              commit1,
    output logic [1:0]                          freeValid,
    output logic [commitPkg::PRF_W-1:0]         freeTag0,
    output logic [commitPkg::PRF_W-1:0]         freeTag1
);

    logic [commitPkg::PRF_W-1:0] map [commitPkg::NUM_ARF];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < commitPkg::NUM_ARF; i++) begin
                map[i] <= commitPkg::PRF_W'(i); // Identity map.
            end
        end else begin
            if (commit0.wrReg) begin
                map[commit0.arf] <= commit0.prf;
            end
            // Younger slot wins on the same register.
            if (commit1.wrReg) begin
                map[commit1.arf] <= commit1.prf;
            end
        end
    end

    assign freeValid = {commit1.wrReg, commit0.wrReg};
    assign freeTag0  = commit0.stale;
    assign freeTag1  = commit1.stale;

    // Rename must have seen the same committed mapping.
    assert property (@(posedge clk) disable iff (rst)
        commit0.wrReg |-> commit0.stale == map[commit0.arf])
        else $error("slot 0 stale tag disagrees with committed map");

endmodule

/* hw/commitPkg.sv */
package commitPkg;

    localparam int NUM_ARF = 32;
    localparam int ARF_W = 5;
    localparam int PRF_W = 6;
    localparam int EXC_W = 5;
    localparam logic [31:0] EXC_VECTOR = 32'hBFC0_0380;

    typedef enum logic [EXC_W-1:0] {
        excInterrupt,
        excAdEL,
        excAdES,
        excSyscall,
        excBreak,
        excReserved,
        excOverflow,
        excEret
    } excCode_e;

    typedef enum logic [2:0] {
        kindNormal,
        kindBranch,
        kindStore,
        kindBubble, // Empty delay slot.
        kindEret
    } uopKind_e;

    // Branch view of the aux word.
    typedef struct packed {
        logic        predTaken;
        logic        branchTaken;
        logic [31:0] predAddr;
        logic [17:0] pad;
    } branchAux_t;

    // Exception view, valid when causeExc is set.
    typedef struct packed {
        excCode_e    code;
        logic [31:0] badVAddr;
        logic [14:0] pad;
    } excAux_t;

    typedef union packed {
        branchAux_t br;
        excAux_t    exc;
    } uopAux_u;

    typedef struct packed {
        logic             valid;
        logic             busy;
        uopKind_e         kind;
        logic [31:0]      pc;
        logic [31:0]      branchAddr; // Resolved target.
        logic             causeExc;
        logic             isDS;
        uopAux_u          aux;
        logic             dstWe;
        logic [ARF_W-1:0] dstL;
        logic [PRF_W-1:0] dstP;
        logic [PRF_W-1:0] dstStale;
    } robUop_t;

    typedef struct packed {
        logic    valid;
        robUop_t uop0;
        robUop_t uop1;
    } robWindow_t;

    typedef struct packed {
        logic        ie;
        logic        exl;
        logic [5:0]  im;
        logic [1:0]  imSw;
        logic [1:0]  ipSw;
        logic        counterInt;
        logic [31:0] epc;
    } cp0Status_t;

    typedef struct packed {
        logic             valid;
        logic             wrReg;
        logic [ARF_W-1:0] arf;
        logic [PRF_W-1:0] prf;
        logic [PRF_W-1:0] stale;
    } commitSlot_t;

    typedef struct packed {
        logic        take;
        excCode_e    code;
        logic [31:0] badVAddr;
        logic [31:0] pc;
        logic        isDS;
        logic [5:0]  intLines;
    } excReport_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

endpackage

/* hw/commitSelect.sv */
`timescale 1ns/1ps

module commitSelect (
    input  logic                   clk,
    input  logic                   rst,
    input  commitPkg::robWindow_t  robWin,
    input  logic                   intPending,
    input  logic [5:0]             intLines,
    input  logic                   flush,
    output commitPkg::commitSlot_t commit0,
    output commitPkg::commitSlot_t commit1,
    output logic [1:0]             storeFire,
    output logic                   mispredict,
    output logic                   waitDs,
    output logic [31:0]            target,
    output commitPkg::excReport_t  excOut
);

    commitPkg::robUop_t    uop0;
    commitPkg::robUop_t    uop1;
    commitPkg::branchAux_t br0;
    logic                  good0;
    logic                  good1;
    logic                  exc0;
    logic                  exc1;
    logic                  intTake;
    logic                  sel0;
    logic                  takeWrong;
    logic                  addrWrong;
    logic                  mispredictNow;
    logic [31:0]           nextTarget;

    assign uop0 = robWin.uop0;
    assign uop1 = robWin.uop1;
    assign br0  = uop0.aux.br;

    // Busy entries come back in a later window.
    assign good0 = robWin.valid && !flush && uop0.valid && !uop0.busy;
    assign good1 = robWin.valid && !flush && uop1.valid && !uop1.busy;

    assign exc0    = good0 && uop0.causeExc;
    assign exc1    = good1 && uop1.causeExc;
    assign intTake = good0 && intPending; // Taken on the head instruction.
    assign sel0    = intTake || exc0;

    // Branch view only when no exception.
    assign takeWrong     = br0.branchTaken != br0.predTaken;
    assign addrWrong     = br0.branchTaken && (br0.predAddr != uop0.branchAddr);
    assign mispredictNow = good0 && !uop0.causeExc && uop0.kind == commitPkg::kindBranch
                           && (takeWrong || addrWrong);
    assign nextTarget    = br0.branchTaken ? uop0.branchAddr : uop0.pc + 32'd8;

    assign storeFire[0] = good0 && uop0.kind == commitPkg::kindStore;
    assign storeFire[1] = good1 && uop1.kind == commitPkg::kindStore;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit0.valid <= 1'b0;
            commit0.wrReg <= 1'b0;
            commit1.valid <= 1'b0;
            commit1.wrReg <= 1'b0;
            mispredict    <= 1'b0;
            waitDs        <= 1'b0;
            excOut.take   <= 1'b0;
        end else begin
            commit0.valid <= good0;
            commit1.valid <= good1;
            commit0.wrReg <= good0 && uop0.dstWe && !sel0;
            commit1.wrReg <= good1 && uop1.dstWe && !sel0 && !exc1;
            mispredict    <= mispredictNow;
            if (mispredictNow) begin
                waitDs <= uop1.kind == commitPkg::kindBubble; // Delay slot not yet here.
            end else if (good0 || good1) begin
                waitDs <= 1'b0;
            end
            excOut.take <= intTake || exc0 || exc1;
        end

        commit0.arf   <= uop0.dstL;
        commit0.prf   <= uop0.dstP;
        commit0.stale <= uop0.dstStale;
        commit1.arf   <= uop1.dstL;
        commit1.prf   <= uop1.dstP;
        commit1.stale <= uop1.dstStale;

        if (mispredictNow) begin
            target <= nextTarget;
        end

        // Interrupt first, then slot 0, then slot 1.
        excOut.code     <= intTake ? commitPkg::excInterrupt :
                           (exc0 ? uop0.aux.exc.code : uop1.aux.exc.code);
        excOut.badVAddr <= sel0 ? uop0.aux.exc.badVAddr : uop1.aux.exc.badVAddr;
        excOut.pc       <= sel0 ? uop0.pc : uop1.pc;
        excOut.isDS     <= sel0 ? uop0.isDS : uop1.isDS;
        excOut.intLines <= intLines;
    end

    // Store strobes must stay known for the store buffer.
    assert property (@(posedge clk) disable iff (rst) !$isunknown(storeFire))
        else $error("store strobe unknown");

endmodule

/* hw/commitTop.sv */
`timescale 1ns/1ps

module commitTop (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [4:0]                  extInt,
    input  commitPkg::cp0Status_t       cp0,
    input  commitPkg::robWindow_t       robWin,
    output commitPkg::commitSlot_t      commit0,
    output commitPkg::commitSlot_t      commit1,
    output logic [1:0]                  freeValid,
    output logic [commitPkg::PRF_W-1:0] freeTag0,
    output logic [commitPkg::PRF_W-1:0] freeTag1,
    output logic [1:0]                  storeFire,
    output commitPkg::excReport_t       excOut,
    output commitPkg::redirect_t        redir,
    output logic                        flush
);

    logic [5:0]  intLines;
    logic        intPending;
    logic        mispredict;
    logic        waitDs;
    logic [31:0] target;

    intSampler uSampler (
        .clk(clk), .rst(rst), .extInt(extInt), .cp0(cp0),
        .intLines(intLines), .intPending(intPending)
    );

    commitSelect uSelect (
        .clk(clk), .rst(rst), .robWin(robWin), .intPending(intPending),
        .intLines(intLines), .flush(flush), .commit0(commit0), .commit1(commit1),
        .storeFire(storeFire), .mispredict(mispredict), .waitDs(waitDs),
        .target(target), .excOut(excOut)
    );

    redirectGen uRedirect (
        .clk(clk), .rst(rst), .mispredict(mispredict), .waitDs(waitDs),
        .target(target), .excOut(excOut), .epc(cp0.epc), .flush(flush), .redir(redir)
    );

    archMap uMap (
        .clk(clk), .rst(rst), .commit0(commit0), .commit1(commit1),
        .freeValid(freeValid), .freeTag0(freeTag0), .freeTag1(freeTag1)
    );

endmodule

/* hw/intSampler.sv */
`timescale 1ns/1ps

module intSampler (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [4:0]           extInt,
    input  commitPkg::cp0Status_t cp0,
    output logic [5:0]           intLines,
    output logic                 intPending
);

    logic [5:0] lines;

    // Timer interrupt sits on the top line.
    always_ff @(posedge clk) begin
        if (rst) begin
            lines <= '0;
        end else begin
            lines <= {cp0.counterInt, extInt};
        end
    end

    assign intLines = lines;

    // Hardware and software lines against the mask.
    assign intPending = (|({lines, cp0.ipSw} & {cp0.im, cp0.imSw})) && cp0.ie && !cp0.exl;

    // Pending state must be known out of reset.
    assert property (@(posedge clk) disable iff (rst) !$isunknown(intPending))
        else $error("interrupt pending unknown");

endmodule

/* hw/redirectGen.sv */
`timescale 1ns/1ps

module redirectGen (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mispredict,
    input  logic                  waitDs,
    input  logic [31:0]           target,
    input  commitPkg::excReport_t excOut,
    input  logic [31:0]           epc,
    output logic                  flush,
    output commitPkg::redirect_t  redir
);

    logic prevWaitDs;
    logic dsResolved;

    always_ff @(posedge clk) begin
        if (rst) begin
            prevWaitDs <= 1'b0;
        end else begin
            prevWaitDs <= waitDs;
        end
    end

    // Delay slot has just arrived.
    assign dsResolved = prevWaitDs && !waitDs;

    always_comb begin
        flush      = 1'b0;
        redir.valid = 1'b0;
        redir.pc    = target;
        if (excOut.take) begin
            flush       = 1'b1;
            redir.valid = 1'b1;
            if (excOut.code == commitPkg::excEret) begin
                redir.pc = epc;
            end else begin
                redir.pc = commitPkg::EXC_VECTOR;
            end
        end else if ((mispredict && !waitDs) || dsResolved) begin
            flush       = 1'b1; // Wrong path behind the branch.
            redir.valid = 1'b1;
        end
    end

    // Flush and redirect travel together, one cycle wide.
    assert property (@(posedge clk) disable iff (rst) flush |-> redir.valid ##1 !flush)
        else $error("flush not a single-cycle redirect pulse");

endmodule

/* list.f */
+incdir+include
hw/commitPkg.sv
hw/intSampler.sv
hw/commitSelect.sv
hw/redirectGen.sv
hw/archMap.sv
hw/commitTop.sv
bench/commitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the commit testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module commitTb -o commitSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/commitSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
